//--- rtl/fetch_pkg.sv
// fetch package with shared widths, bus commands and memory timing for the fetch block

package fetch_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int addr_width     = 32;   // byte address
	localparam int inst_width     = 32;   // one instruction
	localparam int mem_word_width = 64;   // imem doubleword, two instructions
	localparam int mem_tag_width  = 4;    // transaction number

	typedef logic [addr_width-1:0]     addr_t;
	typedef logic [inst_width-1:0]     inst_t;
	typedef logic [mem_word_width-1:0] mem_word_t;
	typedef logic [mem_tag_width-1:0]  mem_tag_t;   // 0 means no transaction

	//////////////////////////////////////////////////
	// memory bus
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		bus_none  = 2'd0,
		bus_load  = 2'd1,
		bus_store = 2'd2    // reserved, never issued by fetch
	} bus_cmd_t;

	// cycles from the request cycle to the cycle the tag comes back
	localparam int mem_latency = 4;

	// 1024 doublewords of instruction memory
	localparam int mem_depth_log2 = 10;

	//////////////////////////////////////////////////
	// core
	//////////////////////////////////////////////////

	localparam addr_t reset_pc = 32'h0000_0000;   // first fetch address

endpackage

//--- rtl/imem_bus_if.sv
// instruction memory bus between the fetch stage and the tagged memory
`timescale 1ns/10ps

interface imem_bus_if;

	fetch_pkg::addr_t     addr;       // doubleword aligned byte address
	fetch_pkg::bus_cmd_t  command;    // bus_load issues a request
	fetch_pkg::mem_word_t data;       // valid in the cycle tag is nonzero
	fetch_pkg::mem_tag_t  response;   // transaction number, same cycle as command
	fetch_pkg::mem_tag_t  tag;        // returns the response mem_latency cycles later

	// fetch side
	modport requester (
		output addr,
		output command,
		input  data,
		input  response,
		input  tag
	);

	// memory side
	modport memory (
		input  addr,
		input  command,
		output data,
		output response,
		output tag
	);

endinterface

//--- rtl/fetch_stage.sv
// fetch stage holding the pc, issuing tagged imem loads and selecting the instruction half
`timescale 1ns/10ps

module fetch_stage (
	input  logic             clock,
	input  logic             reset,
	input  logic             fetch_enable,   // level, low stalls new requests
	input  logic             take_branch,    // strobe, redirect to target_pc
	input  fetch_pkg::addr_t target_pc,
	imem_bus_if.requester    bus,
	output logic             inst_valid,     // one cycle per delivered instruction
	output fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t inst_pc,
	output fetch_pkg::addr_t inst_npc
);

	typedef enum logic [1:0] {
		state_idle,       // after reset or while stalled
		state_request,    // reply just consumed, may issue again
		state_mem_wait    // one load outstanding
	} fetch_state_t;

	fetch_state_t        state;
	fetch_state_t        state_next;
	fetch_pkg::addr_t    pc;                  // address being fetched
	fetch_pkg::addr_t    pc_plus_4;
	fetch_pkg::addr_t    pc_next;             // loaded when the reply returns
	fetch_pkg::mem_tag_t recorded_response;   // transaction number we wait for
	logic                redirect_pending;    // branch seen while a load was in flight
	fetch_pkg::addr_t    redirect_pc;
	logic                issue;               // load goes out this cycle
	logic                reply;               // our tag is back this cycle

	//////////////////////////////////////////////////
	// request and reply detection
	//////////////////////////////////////////////////

	// a taken branch forces a request even when stalled so it is never lost
	assign issue = (state != state_mem_wait) && (fetch_enable || take_branch);
	assign reply = (state == state_mem_wait) && (bus.tag == recorded_response);

	assign bus.command = issue ? fetch_pkg::bus_load : fetch_pkg::bus_none;
	assign bus.addr    = {pc[fetch_pkg::addr_width-1:3], 3'b000};   // doubleword aligned

	//////////////////////////////////////////////////
	// next pc
	//////////////////////////////////////////////////

	assign pc_plus_4 = pc + 32'd4;

	// a branch in the reply cycle wins over one remembered from the wait
	always_comb begin
		if (take_branch)
			pc_next = target_pc;
		else if (redirect_pending)
			pc_next = redirect_pc;
		else
			pc_next = pc_plus_4;
	end

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			state_idle, state_request: begin
				// back to idle when nothing is asked for
				state_next = issue ? state_mem_wait : state_idle;
			end
			state_mem_wait: begin
				if (reply)
					state_next = state_request;
			end
			default: state_next = state_idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state             <= state_idle;
			pc                <= fetch_pkg::reset_pc;
			recorded_response <= '0;
			redirect_pending  <= 1'b0;
		end else begin
			state <= state_next;
			if (issue)
				recorded_response <= bus.response;   // memory never answers 0
			if (reply) begin
				pc               <= pc_next;
				redirect_pending <= 1'b0;             // consumed with this reply
			end else if (take_branch) begin
				redirect_pending <= 1'b1;             // in-flight load fetches a dead path
			end
		end
	end

	// branch target held until the outstanding reply returns
	always_ff @(posedge clock) begin
		if (take_branch && !reply)
			redirect_pc <= target_pc;
	end

	//////////////////////////////////////////////////
	// fetch packet
	//////////////////////////////////////////////////

	assign inst_valid = reply && !redirect_pending;   // drop the reply of a redirected fetch
	assign inst       = pc[2] ? bus.data[63:32] : bus.data[31:0];   // pick the half
	assign inst_pc    = pc;
	assign inst_npc   = pc_plus_4;

endmodule

//--- rtl/imem_model.sv
// instruction memory model with tagged fixed-latency replies and a preload write port
`timescale 1ns/10ps

module imem_model (
	input  logic                 clock,
	input  logic                 reset,
	imem_bus_if.memory           bus,
	input  logic                 load_enable,   // write strobe for program load
	input  fetch_pkg::addr_t     load_addr,     // byte address, bits above 2 pick the word
	input  fetch_pkg::mem_word_t load_data
);

	// doubleword storage, no reset
	fetch_pkg::mem_word_t mem [2**fetch_pkg::mem_depth_log2];

	logic [fetch_pkg::mem_depth_log2-1:0] load_index;
	logic [fetch_pkg::mem_depth_log2-1:0] read_index;

	fetch_pkg::mem_tag_t next_tag;   // number handed to the next load
	logic                is_load;

	// in-flight requests, entry 0 is the newest
	fetch_pkg::mem_tag_t pipe_tag  [fetch_pkg::mem_latency];
	fetch_pkg::addr_t    pipe_addr [fetch_pkg::mem_latency];

	//////////////////////////////////////////////////
	// program load port
	//////////////////////////////////////////////////

	assign load_index = load_addr[fetch_pkg::mem_depth_log2+2:3];

	always_ff @(posedge clock) begin
		if (load_enable)
			mem[load_index] <= load_data;   // visible from the next edge on
	end

	//////////////////////////////////////////////////
	// transaction numbers
	//////////////////////////////////////////////////

	assign is_load      = (bus.command == fetch_pkg::bus_load);
	assign bus.response = is_load ? next_tag : '0;   // never refuses, so never 0 on a load

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			next_tag <= 4'd1;
		end else if (is_load) begin
			// 1..15 then back to 1, skipping 0
			if (next_tag == '1)
				next_tag <= 4'd1;
			else
				next_tag <= next_tag + 4'd1;
		end
	end

	//////////////////////////////////////////////////
	// reply delay line
	//////////////////////////////////////////////////

	// tags are control, cleared on reset so no stray reply comes out
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < fetch_pkg::mem_latency; i++)
				pipe_tag[i] <= '0;
		end else begin
			pipe_tag[0] <= bus.response;   // 0 when no load this cycle
			for (int i = 1; i < fetch_pkg::mem_latency; i++)
				pipe_tag[i] <= pipe_tag[i-1];
		end
	end

	// addresses ride along with their tags
	always_ff @(posedge clock) begin
		pipe_addr[0] <= bus.addr;
		for (int i = 1; i < fetch_pkg::mem_latency; i++)
			pipe_addr[i] <= pipe_addr[i-1];
	end

	//////////////////////////////////////////////////
	// reply
	//////////////////////////////////////////////////

	// read at the address of the entry leaving the line
	assign read_index = pipe_addr[fetch_pkg::mem_latency-1][fetch_pkg::mem_depth_log2+2:3];

	assign bus.tag  = pipe_tag[fetch_pkg::mem_latency-1];
	assign bus.data = mem[read_index];   // only meaningful while tag is nonzero

endmodule

//--- rtl/fetch_top.sv
// fetch top level joining the fetch stage to its tagged instruction memory
`timescale 1ns/10ps

module fetch_top (
	input  logic                 clock,
	input  logic                 reset,

	// fetch control
	input  logic                 fetch_enable,
	input  logic                 take_branch,
	input  fetch_pkg::addr_t     target_pc,

	// program load into the imem
	input  logic                 load_enable,
	input  fetch_pkg::addr_t     load_addr,
	input  fetch_pkg::mem_word_t load_data,

	// fetch packet
	output logic                 inst_valid,
	output fetch_pkg::inst_t     inst,
	output fetch_pkg::addr_t     inst_pc,
	output fetch_pkg::addr_t     inst_npc
);

	imem_bus_if bus ();   // fetch to imem

	fetch_stage u_fetch (
		.clock        (clock),
		.reset        (reset),
		.fetch_enable (fetch_enable),
		.take_branch  (take_branch),
		.target_pc    (target_pc),
		.bus          (bus.requester),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_pc      (inst_pc),
		.inst_npc     (inst_npc)
	);

	imem_model u_imem (
		.clock       (clock),
		.reset       (reset),
		.bus         (bus.memory),
		.load_enable (load_enable),
		.load_addr   (load_addr),
		.load_data   (load_data)
	);

endmodule

//--- bench/fetch_chk.sv
// bus and fetch packet assertions bound into the fetch stage
`timescale 1ns/10ps

module fetch_chk (
	input logic                clock,
	input logic                reset,
	input fetch_pkg::bus_cmd_t command,
	input fetch_pkg::addr_t    addr,
	input fetch_pkg::mem_tag_t response,
	input fetch_pkg::mem_tag_t tag,
	input fetch_pkg::mem_tag_t recorded_response,
	input logic                inst_valid,
	input fetch_pkg::addr_t    inst_pc
);

	int failures = 0;   // read by the bench summary
	int cycles_since_load;   // saturates at mem_latency

	// the wait window spans the mem_latency cycles after each load
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			cycles_since_load <= fetch_pkg::mem_latency;
		else if (command == fetch_pkg::bus_load)
			cycles_since_load <= 0;
		else if (cycles_since_load < fetch_pkg::mem_latency)
			cycles_since_load <= cycles_since_load + 1;
	end

	// only one load in flight, none while its reply is still on the way
	no_load_in_wait: assert property (@(posedge clock) disable iff (reset)
		command == fetch_pkg::bus_load |-> cycles_since_load >= fetch_pkg::mem_latency)
		else begin
			failures++;
			$error("load issued while waiting for a reply");
		end

	// a delivered instruction belongs to our own transaction
	valid_has_tag: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> (tag != '0) && (tag == recorded_response)
			&& (recorded_response == $past(response, fetch_pkg::mem_latency)))
		else begin
			failures++;
			$error("inst_valid without the matching reply tag");
		end

	// request behind a delivered instruction went to the aligned doubleword of its pc
	addr_aligned: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> $past(addr, fetch_pkg::mem_latency)
			== {inst_pc[fetch_pkg::addr_width-1:3], 3'b000})
		else begin
			failures++;
			$error("bus address not the doubleword aligned pc");
		end

endmodule

bind fetch_stage fetch_chk chk_i (
	.clock             (clock),
	.reset             (reset),
	.command           (bus.command),
	.addr              (bus.addr),
	.response          (bus.response),
	.tag               (bus.tag),
	.recorded_response (recorded_response),
	.inst_valid        (inst_valid),
	.inst_pc           (inst_pc)
);

//--- bench/fetch_tb.sv
// testbench for the fetch top level, checks the fetch packet against a reference model of the pc
`timescale 1ns/10ps

module fetch_tb;

	localparam int clock_period = 8;
	localparam int mem_words    = 2**fetch_pkg::mem_depth_log2;
	// 1024 load cycles plus roughly 200 fetches at 5 cycles each, with ample margin
	localparam int max_cycles   = 4000;

	logic                 clock;
	logic                 reset;
	logic                 fetch_enable;
	logic                 take_branch;
	fetch_pkg::addr_t     target_pc;
	logic                 load_enable;
	fetch_pkg::addr_t     load_addr;
	fetch_pkg::mem_word_t load_data;
	logic                 inst_valid;
	fetch_pkg::inst_t     inst;
	fetch_pkg::addr_t     inst_pc;
	fetch_pkg::addr_t     inst_npc;

	fetch_pkg::mem_word_t mem_copy [mem_words];   // what was written into the imem
	integer               seed;
	int                   error_count = 0;
	int                   check_count = 0;
	int                   valid_count = 0;        // delivered instructions so far
	int                   cycle_count = 0;
	fetch_pkg::addr_t     model_pc;               // pc the next valid must carry
	fetch_pkg::addr_t     last_inst_pc = '0;
	string                current_test;

	fetch_top dut_i (
		.clock        (clock),
		.reset        (reset),
		.fetch_enable (fetch_enable),
		.take_branch  (take_branch),
		.target_pc    (target_pc),
		.load_enable  (load_enable),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_pc      (inst_pc),
		.inst_npc     (inst_npc)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	//////////////////////////////////////////////////
	// reference and checking
	//////////////////////////////////////////////////

	// low half of the doubleword for pc bit 2 clear, high half for bit 2 set
	function automatic fetch_pkg::inst_t expected_inst(input fetch_pkg::addr_t pc);
		fetch_pkg::mem_word_t word;
		word = mem_copy[pc[fetch_pkg::mem_depth_log2+2:3]];
		return pc[2] ? word[63:32] : word[31:0];
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s, %s: expected %h, actual %h",
				current_test, what, expected, actual);
		end
	endtask

	// outputs are settled by the falling edge, inputs were driven after the rising one
	always @(negedge clock) begin
		if (!reset && inst_valid) begin
			check_value("inst_pc", model_pc, inst_pc);
			check_value("inst_npc", model_pc + 32'd4, inst_npc);
			check_value("inst", expected_inst(model_pc), inst);
			last_inst_pc = inst_pc;
			valid_count++;
		end
		// a branch on a valid or during the wait both steer the next fetch
		if (!reset && take_branch)
			model_pc = target_pc;
		else if (!reset && inst_valid)
			model_pc = model_pc + 32'd4;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: no end of test after %0d cycles, fetch stopped delivering",
				cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	task automatic next_edge();
		@(posedge clock);
		#1;   // drive just after the edge
	endtask

	// returns in the cycle after the last wanted valid
	task automatic wait_instructions(input int count);
		int target;
		target = valid_count + count;
		while (valid_count < target)
			next_edge();
	endtask

	task automatic wait_valid_cycle();
		while (!inst_valid)
			next_edge();
	endtask

	task automatic load_program();
		load_enable = 1'b1;
		for (int i = 0; i < mem_words; i++) begin
			mem_copy[i] = {$random(seed), $random(seed)};
			load_addr   = fetch_pkg::addr_t'(i * 8);   // byte address of doubleword i
			load_data   = mem_copy[i];
			next_edge();
		end
		load_enable = 1'b0;
	endtask

	// stall with one load in flight, it must still come back
	task automatic stall_with_outstanding(input int stall_cycles);
		int               held;
		fetch_pkg::addr_t pc_before;
		next_edge();                // request went out, now waiting
		fetch_enable = 1'b0;
		wait_instructions(1);
		held      = valid_count;
		pc_before = last_inst_pc;
		repeat (stall_cycles)
			next_edge();
		check_value("valid count while stalled", held, valid_count);
		fetch_enable = 1'b1;
		wait_instructions(1);
		check_value("pc after stall", pc_before + 32'd4, last_inst_pc);   // no skip, no repeat
		wait_instructions(3);
	endtask

	task automatic branch_on_valid(input fetch_pkg::addr_t target);
		wait_valid_cycle();
		take_branch = 1'b1;
		target_pc   = target;
		next_edge();
		take_branch = 1'b0;
		wait_instructions(1);
		check_value("pc after branch", target, last_inst_pc);
		wait_instructions(3);
	endtask

	// branch one cycle into the wait, the pending reply must not show up
	task automatic redirect_in_wait(input fetch_pkg::addr_t target);
		next_edge();
		take_branch = 1'b1;
		target_pc   = target;
		next_edge();
		take_branch = 1'b0;
		wait_instructions(1);
		check_value("pc after redirect", target, last_inst_pc);
		wait_instructions(3);   // runs on through both halves from the target
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		seed         = 5;
		reset        = 1'b1;
		fetch_enable = 1'b0;
		take_branch  = 1'b0;
		target_pc    = '0;
		load_enable  = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		model_pc     = fetch_pkg::reset_pc;
		current_test = "reset";

		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		check_value("inst_valid", 1'b0, inst_valid);

		current_test = "program_load";
		load_program();

		current_test = "first_fetch";
		fetch_enable = 1'b1;
		wait_instructions(1);
		check_value("first inst_pc", fetch_pkg::reset_pc, last_inst_pc);

		current_test = "sequential";
		wait_instructions(64);
		check_value("last inst_pc", fetch_pkg::reset_pc + 32'd256, last_inst_pc);

		current_test = "stall";
		stall_with_outstanding(20);

		current_test = "branch_on_valid_low";
		branch_on_valid(32'h0000_0200);
		current_test = "branch_on_valid_high";
		branch_on_valid(32'h0000_0314);

		current_test = "redirect_aligned";
		redirect_in_wait(32'h0000_0600);
		current_test = "redirect_unaligned";
		redirect_in_wait(32'h0000_0a04);

		fetch_enable = 1'b0;
		repeat (8)
			next_edge();   // let the last reply drain
		error_count += dut_i.u_fetch.chk_i.failures;

		$display("summary: %0d checks, %0d instructions, %0d assertion failures, %0d errors",
			check_count, valid_count, dut_i.u_fetch.chk_i.failures, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- build.f
rtl/fetch_pkg.sv
rtl/imem_bus_if.sv
rtl/fetch_stage.sv
rtl/imem_model.sv
rtl/fetch_top.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f build.f -o fetch_sim

# keep running past an assertion failure so the bench prints its summary
if ! out=$(./obj_dir/fetch_sim +verilator+error+limit+1000); then
	echo "$out"
	echo "simulation exited with an error"
	exit 1
fi
echo "$out"

echo "$out" | grep -qx "All tests passed"
